// File: compile.f
rip_const.sv
rip_axi_interface.sv
rip_mem_req_if.sv
rip_axi_master.sv
rip_pseudo_core.sv
rip_core_top.sv
tb_clkgen.sv
tb_axi_mem.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_top -f compile.f -o Vtb_top
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    exit 0
fi
echo "Pass message missing from $LOG"
exit 1

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import rip_const::*;

    localparam logic [31:0] SEED = 32'h6c07b350;
    localparam logic [31:0] BASE1 = 32'h0000_1000;
    localparam logic [31:0] BASE2 = 32'h0000_2400;
    localparam int DATA_LEN = 16;
    localparam int PASS_TIMEOUT = 4000;

    logic clk;
    logic rstn;
    logic [31:0] mem_head;
    logic [1:0] busy;
    logic [31:0] m_axi_awaddr, m_axi_wdata, m_axi_araddr, m_axi_rdata;
    logic [3:0] m_axi_wstrb;
    logic [3:0] m_axi_awid, m_axi_arid;
    logic [7:0] m_axi_awlen, m_axi_arlen;
    logic [2:0] m_axi_awsize, m_axi_arsize;
    logic [1:0] m_axi_awburst, m_axi_arburst;
    logic m_axi_wlast;
    logic m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready;
    logic m_axi_bvalid, m_axi_bready, m_axi_arvalid, m_axi_arready;
    logic m_axi_rvalid, m_axi_rready;
    logic rd_seen, wr_seen;
    logic [31:0] rd_addr, rd_data, wr_addr, wr_data;
    logic [3:0] wr_strb;

    // Scoreboard state owned by the checker
    int word_n = 0;
    int passes = 0;
    int base2_passes = 0;
    logic expect_write = 1'b0;
    logic saw_idle = 1'b0;
    logic idle_check = 1'b0;
    logic [31:0] pass_base = '1;
    logic [31:0] exp_addr;
    logic rd_act, wr_act;
    logic aw_wait, w_wait, ar_wait;
    logic [31:0] aw_addr_prev, w_data_prev, ar_addr_prev;
    logic [3:0] w_strb_prev, aw_id_prev, ar_id_prev;

    tb_clkgen #(.RESET_CYCLES(10)) u_clk (.clk(clk), .rstn(rstn));

    rip_core_top #(
        .ADDR_WIDTH(32),
        .DATA_WIDTH(32),
        .AXI_ID_WIDTH(4),
        .DATA_LEN(DATA_LEN)
    ) u_dut (
        .clk(clk), .rstn(rstn), .mem_head(mem_head), .busy(busy),
        .m_axi_awid(m_axi_awid), .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen),
        .m_axi_awsize(m_axi_awsize), .m_axi_awburst(m_axi_awburst),
        .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
        .m_axi_wdata(m_axi_wdata), .m_axi_wstrb(m_axi_wstrb), .m_axi_wlast(m_axi_wlast),
        .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready),
        .m_axi_bid(4'd0), .m_axi_bresp(2'b00), .m_axi_bvalid(m_axi_bvalid),
        .m_axi_bready(m_axi_bready),
        .m_axi_arid(m_axi_arid), .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen),
        .m_axi_arsize(m_axi_arsize), .m_axi_arburst(m_axi_arburst),
        .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
        .m_axi_rid(4'd0), .m_axi_rdata(m_axi_rdata), .m_axi_rresp(2'b00),
        .m_axi_rlast(1'b1), .m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready)
    );

    tb_axi_mem #(.SEED(SEED)) u_mem (
        .clk(clk), .rstn(rstn),
        .awaddr(m_axi_awaddr), .awvalid(m_axi_awvalid), .awready(m_axi_awready),
        .wdata(m_axi_wdata), .wstrb(m_axi_wstrb), .wvalid(m_axi_wvalid), .wready(m_axi_wready),
        .bvalid(m_axi_bvalid), .bready(m_axi_bready),
        .araddr(m_axi_araddr), .arvalid(m_axi_arvalid), .arready(m_axi_arready),
        .rdata(m_axi_rdata), .rvalid(m_axi_rvalid), .rready(m_axi_rready),
        .rd_seen(rd_seen), .rd_addr(rd_addr), .rd_data(rd_data),
        .wr_seen(wr_seen), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] expected_addr(input logic [31:0] base, input logic [31:0] n);
        return base | (n << 2);
    endfunction

    function automatic logic [31:0] expected_data(input logic [31:0] addr);
        return xorshift32(SEED ^ addr); // Preload survives the write-back
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("[FAIL] %s exp=%h got=%h", name, exp, got);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic rule_error(input string what);
        $display("Protocol error: %s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic timeout_error(input string what);
        $display("Timeout: %s never happened", what);
        $display("Errors found");
        $fatal(1);
    endtask

    // One 4-byte INCR beat per burst
    task automatic check_single_beat(input string ch, input logic [7:0] len,
                                     input logic [2:0] size, input logic [1:0] burst);
        assert (len == 8'd0) else value_error({ch, "len"}, 32'h0, 32'(len));
        assert (size == 3'b010) else value_error({ch, "size"}, 32'h2, 32'(size));
        assert (burst == 2'b01) else value_error({ch, "burst"}, 32'h1, 32'(burst));
    endtask

    always @(negedge clk) begin
        if (!rstn) begin
            word_n = 0;
            expect_write = 1'b0;
            saw_idle = 1'b0;
            aw_wait = 1'b0;
            w_wait = 1'b0;
            ar_wait = 1'b0;
        end else begin
            rd_act = m_axi_arvalid || m_axi_rready;
            wr_act = m_axi_awvalid || m_axi_wvalid || m_axi_bready;
            if (busy == BUSY_INIT) begin
                pass_base = mem_head; // Base that INIT confirms at the next edge
            end
            if (busy == BUSY_SLEEP || busy == BUSY_INIT) begin
                saw_idle = 1'b1;
            end
            if (idle_check) begin
                assert (busy == BUSY_SLEEP) else value_error("busy", 32'(BUSY_SLEEP), 32'(busy));
                assert (!rd_act && !wr_act) else rule_error("AXI request raised while idle");
            end
            assert (!(rd_act && wr_act)) else rule_error("read and write active together");
            if (rd_act) begin
                assert (busy == BUSY_READ) else value_error("busy", 32'(BUSY_READ), 32'(busy));
            end
            if (wr_act) begin
                assert (busy == BUSY_WRITE) else value_error("busy", 32'(BUSY_WRITE), 32'(busy));
            end
            if (aw_wait) begin
                assert (m_axi_awvalid) else rule_error("AWVALID dropped before AWREADY");
                assert (m_axi_awaddr == aw_addr_prev)
                    else value_error("awaddr", aw_addr_prev, m_axi_awaddr);
                assert (m_axi_awid == aw_id_prev)
                    else value_error("awid", 32'(aw_id_prev), 32'(m_axi_awid));
            end
            if (w_wait) begin
                assert (m_axi_wvalid) else rule_error("WVALID dropped before WREADY");
                assert (m_axi_wdata == w_data_prev)
                    else value_error("wdata", w_data_prev, m_axi_wdata);
                assert (m_axi_wstrb == w_strb_prev)
                    else value_error("wstrb", 32'(w_strb_prev), 32'(m_axi_wstrb));
            end
            if (ar_wait) begin
                assert (m_axi_arvalid) else rule_error("ARVALID dropped before ARREADY");
                assert (m_axi_araddr == ar_addr_prev)
                    else value_error("araddr", ar_addr_prev, m_axi_araddr);
                assert (m_axi_arid == ar_id_prev)
                    else value_error("arid", 32'(ar_id_prev), 32'(m_axi_arid));
            end
            if (m_axi_awvalid) begin
                check_single_beat("aw", m_axi_awlen, m_axi_awsize, m_axi_awburst);
            end
            if (m_axi_arvalid) begin
                check_single_beat("ar", m_axi_arlen, m_axi_arsize, m_axi_arburst);
            end
            if (m_axi_wvalid) begin
                assert (m_axi_wlast) else value_error("wlast", 32'h1, 32'(m_axi_wlast));
            end
            if (rd_seen) begin
                exp_addr = expected_addr(pass_base, word_n);
                assert (!expect_write) else rule_error("read issued before the write of the word");
                if (word_n == 0) begin
                    assert (saw_idle) else rule_error("new pass started without sleep or init");
                end else begin
                    assert (!saw_idle) else rule_error("core left the pass before its end");
                end
                assert (rd_addr == exp_addr) else value_error("araddr", exp_addr, rd_addr);
                assert (rd_data == expected_data(exp_addr))
                    else value_error("rdata", expected_data(exp_addr), rd_data);
                expect_write = 1'b1;
                saw_idle = 1'b0;
            end
            if (wr_seen) begin
                exp_addr = expected_addr(pass_base, word_n);
                assert (expect_write) else rule_error("write issued without a read before it");
                assert (wr_addr == exp_addr) else value_error("awaddr", exp_addr, wr_addr);
                assert (wr_data == expected_data(exp_addr))
                    else value_error("wdata", expected_data(exp_addr), wr_data);
                assert (wr_strb == 4'hf) else value_error("wstrb", 32'hf, 32'(wr_strb));
                expect_write = 1'b0;
                word_n = word_n + 1;
                if (word_n == DATA_LEN) begin
                    word_n = 0;
                    passes = passes + 1;
                    if (pass_base == BASE2) begin
                        base2_passes = base2_passes + 1;
                    end
                end
            end
            aw_wait = m_axi_awvalid && !m_axi_awready; // Handshake at the next edge otherwise
            w_wait = m_axi_wvalid && !m_axi_wready;
            ar_wait = m_axi_arvalid && !m_axi_arready;
            aw_addr_prev = m_axi_awaddr;
            w_data_prev = m_axi_wdata;
            w_strb_prev = m_axi_wstrb;
            ar_addr_prev = m_axi_araddr;
            aw_id_prev = m_axi_awid;
            ar_id_prev = m_axi_arid;
        end
    end

    initial begin
        int cycles;
        mem_head <= '1;
        cycles = 0;
        while (!rstn) begin
            @(posedge clk);
            cycles++;
            if (cycles > 50) timeout_error("reset release");
        end
        idle_check = 1'b1;
        repeat (200) @(posedge clk);
        idle_check = 1'b0;
        mem_head <= BASE1;
        cycles = 0;
        while (passes < 1) begin
            @(posedge clk);
            cycles++;
            if (cycles > PASS_TIMEOUT) timeout_error("end of the first pass");
        end
        mem_head <= BASE2;
        cycles = 0;
        while (base2_passes < 2) begin
            @(posedge clk);
            cycles++;
            if (cycles > 3 * PASS_TIMEOUT) timeout_error("end of two passes at the second base");
        end
        cycles = 0;
        while (word_n < DATA_LEN / 2) begin
            @(posedge clk);
            cycles++;
            if (cycles > PASS_TIMEOUT) timeout_error("middle of the third pass");
        end
        mem_head <= '1; // Current pass must still run to its end
        repeat (2) @(posedge clk);
        cycles = 0;
        @(negedge clk);
        while (busy != BUSY_SLEEP) begin
            @(negedge clk);
            cycles++;
            if (cycles > PASS_TIMEOUT) timeout_error("return to sleep after the last pass");
        end
        @(posedge clk);
        idle_check = 1'b1;
        repeat (100) @(posedge clk);
        assert (word_n == 0 && !expect_write) else rule_error("last pass ended part way");
        $display("No errors");
        $finish;
    end

endmodule

// File: tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter logic [31:0] SEED = 32'h6c07b350
) (
    input wire clk,
    input wire rstn,
    input wire [31:0] awaddr,
    input wire awvalid,
    output logic awready,
    input wire [31:0] wdata,
    input wire [3:0] wstrb,
    input wire wvalid,
    output logic wready,
    output logic bvalid,
    input wire bready,
    input wire [31:0] araddr,
    input wire arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic rvalid,
    input wire rready,
    output logic rd_seen,
    output logic [31:0] rd_addr,
    output logic [31:0] rd_data,
    output logic wr_seen,
    output logic [31:0] wr_addr,
    output logic [31:0] wr_data,
    output logic [3:0] wr_strb
);

    logic [31:0] store [logic [31:0]]; // Only written words, the rest is preload
    logic [31:0] rnd;
    logic aw_got;
    logic w_got;
    logic ar_got;
    logic [31:0] aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0] w_strb_q;
    logic [31:0] ar_addr_q;
    logic aw_take;
    logic w_take;
    logic ar_take;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (store.exists(a)) begin
            return store[a];
        end
        return xorshift32(SEED ^ a); // Preload from the full address
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] word;
        word = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return word;
    endfunction

    assign aw_take = awvalid && awready;
    assign w_take  = wvalid && wready;
    assign ar_take = arvalid && arready;

    initial begin
        awready <= 1'b0;
        wready <= 1'b0;
        bvalid <= 1'b0;
        arready <= 1'b0;
        rvalid <= 1'b0;
        rdata <= '0;
        rd_seen <= 1'b0;
        wr_seen <= 1'b0;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            rnd <= SEED;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            arready <= 1'b0;
            rvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
            ar_got <= 1'b0;
            rd_seen <= 1'b0;
            wr_seen <= 1'b0;
        end else begin
            rnd <= xorshift32(rnd);
            rd_seen <= 1'b0;
            wr_seen <= 1'b0;
            awready <= !aw_got && !aw_take && (rnd[1:0] != 2'b00);
            wready <= !w_got && !w_take && (rnd[3:2] != 2'b00);
            arready <= !ar_got && !ar_take && (rnd[9:8] != 2'b00);
            if (aw_take) begin
                aw_got <= 1'b1;
                aw_addr_q <= awaddr;
            end
            if (w_take) begin
                w_got <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got <= 1'b0;
                store[aw_addr_q] = merge_bytes(read_word(aw_addr_q), w_data_q, w_strb_q);
                wr_seen <= 1'b1;
                wr_addr <= aw_addr_q;
                wr_data <= w_data_q;
                wr_strb <= w_strb_q;
            end else if (!bvalid && aw_got && w_got && rnd[5:4] == 2'b00) begin
                bvalid <= 1'b1;
            end
            if (ar_take) begin
                ar_got <= 1'b1;
                ar_addr_q <= araddr;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                ar_got <= 1'b0;
                rd_seen <= 1'b1;
                rd_addr <= ar_addr_q;
                rd_data <= rdata;
            end else if (!rvalid && ar_got && rnd[7:6] == 2'b00) begin
                rvalid <= 1'b1;
                rdata <= read_word(ar_addr_q);
            end
        end
    end

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rstn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// File: rip_core_top.sv
`default_nettype none
`timescale 1ns/1ps

module rip_core_top #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    parameter int AXI_ID_WIDTH = 4,
    parameter int DATA_LEN = 256
) (
    input wire clk,
    input wire rstn,
    input wire [ADDR_WIDTH-1:0] mem_head,
    output wire [1:0] busy,

    output wire [AXI_ID_WIDTH-1:0] m_axi_awid,
    output wire [ADDR_WIDTH-1:0] m_axi_awaddr,
    output wire [7:0] m_axi_awlen,
    output wire [2:0] m_axi_awsize,
    output wire [1:0] m_axi_awburst,
    output wire m_axi_awvalid,
    input wire m_axi_awready,

    output wire [DATA_WIDTH-1:0] m_axi_wdata,
    output wire [DATA_WIDTH/rip_const::B_WIDTH-1:0] m_axi_wstrb,
    output wire m_axi_wlast,
    output wire m_axi_wvalid,
    input wire m_axi_wready,

    input wire [AXI_ID_WIDTH-1:0] m_axi_bid,
    input wire [1:0] m_axi_bresp,
    input wire m_axi_bvalid,
    output wire m_axi_bready,

    output wire [AXI_ID_WIDTH-1:0] m_axi_arid,
    output wire [ADDR_WIDTH-1:0] m_axi_araddr,
    output wire [7:0] m_axi_arlen,
    output wire [2:0] m_axi_arsize,
    output wire [1:0] m_axi_arburst,
    output wire m_axi_arvalid,
    input wire m_axi_arready,

    input wire [AXI_ID_WIDTH-1:0] m_axi_rid,
    input wire [DATA_WIDTH-1:0] m_axi_rdata,
    input wire [1:0] m_axi_rresp,
    input wire m_axi_rlast,
    input wire m_axi_rvalid,
    output wire m_axi_rready
);

    rip_mem_req_if #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) req_if ();

    rip_axi_interface #(
        .ID_WIDTH(AXI_ID_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) axi_if ();

    rip_pseudo_core #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH),
        .DATA_LEN(DATA_LEN)
    ) u_core (
        .clk(clk),
        .rstn(rstn),
        .mem_head(mem_head),
        .busy(busy),
        .req(req_if.core)
    );

    rip_axi_master #(
        .ID_WIDTH(AXI_ID_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_axim (
        .clk(clk),
        .rstn(rstn),
        .req(req_if.master),
        .m_axi(axi_if.master)
    );

    // Master to slave
    assign m_axi_awid    = axi_if.awid;
    assign m_axi_awaddr  = axi_if.awaddr;
    assign m_axi_awlen   = axi_if.awlen;
    assign m_axi_awsize  = axi_if.awsize;
    assign m_axi_awburst = axi_if.awburst;
    assign m_axi_awvalid = axi_if.awvalid;
    assign m_axi_wdata   = axi_if.wdata;
    assign m_axi_wstrb   = axi_if.wstrb;
    assign m_axi_wlast   = axi_if.wlast;
    assign m_axi_wvalid  = axi_if.wvalid;
    assign m_axi_bready  = axi_if.bready;
    assign m_axi_arid    = axi_if.arid;
    assign m_axi_araddr  = axi_if.araddr;
    assign m_axi_arlen   = axi_if.arlen;
    assign m_axi_arsize  = axi_if.arsize;
    assign m_axi_arburst = axi_if.arburst;
    assign m_axi_arvalid = axi_if.arvalid;
    assign m_axi_rready  = axi_if.rready;

    // Slave to master
    assign axi_if.awready = m_axi_awready;
    assign axi_if.wready  = m_axi_wready;
    assign axi_if.bid     = m_axi_bid;
    assign axi_if.bresp   = m_axi_bresp;
    assign axi_if.bvalid  = m_axi_bvalid;
    assign axi_if.arready = m_axi_arready;
    assign axi_if.rid     = m_axi_rid;
    assign axi_if.rdata   = m_axi_rdata;
    assign axi_if.rresp   = m_axi_rresp;
    assign axi_if.rlast   = m_axi_rlast;
    assign axi_if.rvalid  = m_axi_rvalid;

endmodule

`default_nettype wire

// File: rip_pseudo_core.sv
`default_nettype none
`timescale 1ns/1ps

module rip_pseudo_core #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    parameter int DATA_LEN = 256
) (
    input wire clk,
    input wire rstn,
    input wire [ADDR_WIDTH-1:0] mem_head,
    output logic [1:0] busy,
    rip_mem_req_if.core req
);
    import rip_const::*;

    localparam int CNT_WIDTH = $clog2(DATA_LEN + 1);

    typedef enum logic [2:0] {
        SLEEP,
        INIT,
        READ,
        READWAIT,
        WRITE,
        WRITEWAIT
    } state_t;

    state_t state;

    logic [ADDR_WIDTH-1:0] base;
    logic [CNT_WIDTH-1:0] cnt;
    logic [ADDR_WIDTH-1:0] addr;

    // Word n sits at base | n*4
    assign addr = base | (ADDR_WIDTH'(cnt) << 2);

    always_comb begin
        case (state)
            SLEEP: busy = BUSY_SLEEP;
            READ, READWAIT: busy = BUSY_READ;
            WRITE, WRITEWAIT: busy = BUSY_WRITE;
            default: busy = BUSY_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= SLEEP;
            cnt <= '0;
            req.rvalid <= 1'b0;
            req.wvalid <= 1'b0;
        end else begin
            case (state)
                SLEEP: begin
                    if (mem_head != '1) begin
                        state <= INIT;
                        cnt <= '0;
                    end
                end
                INIT: begin
                    if (mem_head == base) begin // Head unchanged since capture
                        state <= READ;
                        req.rvalid <= 1'b1;
                    end else begin
                        state <= SLEEP;
                    end
                end
                READ: begin
                    if (req.rvalid && req.rready) begin
                        state <= READWAIT;
                        req.rvalid <= 1'b0;
                    end
                end
                READWAIT: begin
                    if (req.rdone) begin
                        state <= WRITE;
                        req.wvalid <= 1'b1;
                    end
                end
                WRITE: begin
                    if (req.wvalid && req.wready) begin
                        state <= WRITEWAIT;
                        cnt <= cnt + 1'b1;
                        req.wvalid <= 1'b0;
                    end
                end
                WRITEWAIT: begin
                    if (req.wdone) begin
                        if (cnt < CNT_WIDTH'(DATA_LEN)) begin
                            state <= READ;
                            req.rvalid <= 1'b1;
                        end else begin
                            state <= SLEEP; // Pass complete
                        end
                    end
                end
                default: state <= SLEEP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SLEEP) begin
            base <= mem_head;
        end
        if (state == INIT || (state == WRITEWAIT && req.wdone)) begin
            req.raddr <= addr;
        end
        if (state == READWAIT && req.rdone) begin
            req.waddr <= addr;
            req.wdata <= req.rdata; // Write back what was read
            req.wstrb <= {(DATA_WIDTH / B_WIDTH){1'b1}};
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        !(req.rvalid && req.wvalid));

    assert property (@(posedge clk) disable iff (!rstn)
        cnt <= CNT_WIDTH'(DATA_LEN));

endmodule

`default_nettype wire

// File: rip_axi_master.sv
`default_nettype none
`timescale 1ns/1ps

module rip_axi_master #(
    parameter int ID_WIDTH = 4,
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input wire clk,
    input wire rstn,
    rip_mem_req_if.master req,
    rip_axi_interface.master m_axi
);
    import rip_const::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_RESP
    } wstate_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } rstate_t;

    wstate_t wstate;
    rstate_t rstate;

    logic aw_valid_q;
    logic w_valid_q;
    logic ar_valid_q;
    logic wdone_q;
    logic rdone_q;

    logic [ADDR_WIDTH-1:0] aw_addr_q;
    logic [DATA_WIDTH-1:0] w_data_q;
    logic [DATA_WIDTH/B_WIDTH-1:0] w_strb_q;
    logic [ADDR_WIDTH-1:0] ar_addr_q;
    logic [DATA_WIDTH-1:0] r_data_q;

    logic aw_ok;
    logic w_ok;

    // Channel finished this cycle or earlier
    assign aw_ok = !aw_valid_q || m_axi.awready;
    assign w_ok  = !w_valid_q || m_axi.wready;

    assign req.wready = (wstate == W_IDLE);
    assign req.wdone  = wdone_q;
    assign req.rready = (rstate == R_IDLE);
    assign req.rdata  = r_data_q;
    assign req.rdone  = rdone_q;

    // Single-beat bursts only
    assign m_axi.awid    = ID_WIDTH'(0);
    assign m_axi.awaddr  = aw_addr_q;
    assign m_axi.awlen   = 8'd0;
    assign m_axi.awsize  = AXI_SIZE_4B;
    assign m_axi.awburst = AXI_BURST_INCR;
    assign m_axi.awvalid = aw_valid_q;
    assign m_axi.wdata   = w_data_q;
    assign m_axi.wstrb   = w_strb_q;
    assign m_axi.wlast   = 1'b1;
    assign m_axi.wvalid  = w_valid_q;
    assign m_axi.bready  = (wstate == W_RESP);
    assign m_axi.arid    = ID_WIDTH'(0);
    assign m_axi.araddr  = ar_addr_q;
    assign m_axi.arlen   = 8'd0;
    assign m_axi.arsize  = AXI_SIZE_4B;
    assign m_axi.arburst = AXI_BURST_INCR;
    assign m_axi.arvalid = ar_valid_q;
    assign m_axi.rready  = (rstate == R_DATA);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wstate <= W_IDLE;
            aw_valid_q <= 1'b0;
            w_valid_q <= 1'b0;
            wdone_q <= 1'b0;
        end else begin
            wdone_q <= 1'b0;
            case (wstate)
                W_IDLE: begin
                    if (req.wvalid) begin // wready is high here
                        wstate <= W_ADDR;
                        aw_valid_q <= 1'b1;
                        w_valid_q <= 1'b1;
                    end
                end
                W_ADDR: begin
                    if (m_axi.awready) begin
                        aw_valid_q <= 1'b0;
                    end
                    if (m_axi.wready) begin
                        w_valid_q <= 1'b0;
                    end
                    if (aw_ok && w_ok) begin
                        wstate <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (m_axi.bvalid) begin // BRESP ignored
                        wstate <= W_IDLE;
                        wdone_q <= 1'b1;
                    end
                end
                default: wstate <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wstate == W_IDLE && req.wvalid) begin
            aw_addr_q <= req.waddr;
            w_data_q <= req.wdata;
            w_strb_q <= req.wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rstate <= R_IDLE;
            ar_valid_q <= 1'b0;
            rdone_q <= 1'b0;
        end else begin
            rdone_q <= 1'b0;
            case (rstate)
                R_IDLE: begin
                    if (req.rvalid) begin
                        rstate <= R_ADDR;
                        ar_valid_q <= 1'b1;
                    end
                end
                R_ADDR: begin
                    if (m_axi.arready) begin
                        rstate <= R_DATA;
                        ar_valid_q <= 1'b0;
                    end
                end
                R_DATA: begin
                    if (m_axi.rvalid) begin // RRESP ignored
                        rstate <= R_IDLE;
                        rdone_q <= 1'b1;
                    end
                end
                default: rstate <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rstate == R_IDLE && req.rvalid) begin
            ar_addr_q <= req.raddr;
        end
        if (rstate == R_DATA && m_axi.rvalid) begin
            r_data_q <= m_axi.rdata;
        end
    end

    // Address held while the slave stalls
    assert property (@(posedge clk) disable iff (!rstn)
        aw_valid_q && !m_axi.awready |=> aw_valid_q && $stable(aw_addr_q));

    // Read done only follows an R handshake
    assert property (@(posedge clk) disable iff (!rstn)
        rdone_q |-> $past(rstate == R_DATA && m_axi.rvalid));

endmodule

`default_nettype wire

// File: rip_mem_req_if.sv
`default_nettype none
`timescale 1ns/1ps

interface rip_mem_req_if #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
);
    import rip_const::*;

    // Write request, core side
    logic [ADDR_WIDTH-1:0] waddr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH/B_WIDTH-1:0] wstrb;
    logic wvalid;
    logic wready; // Master idle on writes
    logic wdone;  // One cycle after B handshake

    // Read request, core side
    logic [ADDR_WIDTH-1:0] raddr;
    logic rvalid;
    logic rready; // Master idle on reads
    logic [DATA_WIDTH-1:0] rdata;
    logic rdone;  // rdata valid in this cycle

    modport core (
        output waddr, wdata, wstrb, wvalid,
        input  wready, wdone,
        output raddr, rvalid,
        input  rready, rdata, rdone
    );

    modport master (
        input  waddr, wdata, wstrb, wvalid,
        output wready, wdone,
        input  raddr, rvalid,
        output rready, rdata, rdone
    );

endinterface

`default_nettype wire

// File: rip_axi_interface.sv
`default_nettype none
`timescale 1ns/1ps

interface rip_axi_interface #(
    parameter int ID_WIDTH = 4,
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
);
    import rip_const::*;

    // Write address channel
    logic [ID_WIDTH-1:0] awid;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic awvalid;
    logic awready;

    // Write data channel
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH/B_WIDTH-1:0] wstrb;
    logic wlast;
    logic wvalid;
    logic wready;

    // Write response channel
    logic [ID_WIDTH-1:0] bid;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;

    // Read address channel
    logic [ID_WIDTH-1:0] arid;
    logic [ADDR_WIDTH-1:0] araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic arvalid;
    logic arready;

    // Read data channel
    logic [ID_WIDTH-1:0] rid;
    logic [DATA_WIDTH-1:0] rdata;
    logic [1:0] rresp;
    logic rlast;
    logic rvalid;
    logic rready;

    modport master (
        output awid, awaddr, awlen, awsize, awburst, awvalid,
        input  awready,
        output wdata, wstrb, wlast, wvalid,
        input  wready,
        input  bid, bresp, bvalid,
        output bready,
        output arid, araddr, arlen, arsize, arburst, arvalid,
        input  arready,
        input  rid, rdata, rresp, rlast, rvalid,
        output rready
    );

    modport slave (
        input  awid, awaddr, awlen, awsize, awburst, awvalid,
        output awready,
        input  wdata, wstrb, wlast, wvalid,
        output wready,
        output bid, bresp, bvalid,
        input  bready,
        input  arid, araddr, arlen, arsize, arburst, arvalid,
        output arready,
        output rid, rdata, rresp, rlast, rvalid,
        input  rready
    );

endinterface

`default_nettype wire

// File: rip_const.sv
package rip_const;

    // Bits per write strobe lane
    localparam int B_WIDTH = 8;

    // Phase codes on the busy output
    localparam logic [1:0] BUSY_SLEEP = 2'b00;
    localparam logic [1:0] BUSY_INIT  = 2'b01;
    localparam logic [1:0] BUSY_READ  = 2'b10;
    localparam logic [1:0] BUSY_WRITE = 2'b11;

    // AXI4 burst and size encodings
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_4B    = 3'b010;

endpackage
